//--- files.f
+incdir+verilog
verilog/gf_pkg.sv
verilog/cop_pkg.sv
verilog/gf_regfile.sv
verilog/gf_bus_arbiter.sv
verilog/gf_mul_engine.sv
verilog/gf_div_engine.sv
verilog/gf_coprocessor.sv
test/gf_coprocessor_tb.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, then search the simulation log for the fail message.
verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module gf_coprocessor_tb -o gf_sim > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build error"; exit 1; }
./obj_dir/gf_sim > sim.log 2>&1 || echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

//--- test/gf_coprocessor_tb.sv
`timescale 1ns/1ps
`include "gf_params.svh"

module gf_coprocessor_tb;

	localparam int OPS   = 16;             // Operations per test.
	localparam int BOUND = 2*`GF_M + 12;   // Cycles allowed per operation.

	logic                clk;
	logic                arst_n;
	logic                host_we;
	logic [`GF_AW-1:0]   host_waddr;
	gf_pkg::elem_t       host_wdata;
	logic [`GF_AW-1:0]   host_raddr;
	gf_pkg::elem_t       host_rdata;
	logic                mul_start;
	gf_pkg::mul_op_t     mul_op;
	logic [`GF_AW-1:0]   mul_dst;
	logic [`GF_AW-1:0]   mul_src_a;
	logic [`GF_AW-1:0]   mul_src_b;
	logic                mul_busy;
	logic                div_start;
	logic [`GF_AW-1:0]   div_dst;
	logic [`GF_AW-1:0]   div_numer;
	logic [`GF_AW-1:0]   div_denom;
	logic                div_busy;
	logic                div_zero;

	gf_pkg::elem_t       model [`GF_REGS]; // Expected register contents.
	gf_pkg::elem_t       chk_exp;
	logic                chk_en;           // Read-back compare this cycle.
	logic                chk_zero;         // Divide-by-zero flag expected.
	logic                zero_seen;
	logic                nz_mode;          // div_zero must stay low.
	logic                dual_watch;       // Both engines running.
	cop_pkg::requester_t first_exp;        // Engine due to finish first.
	cop_pkg::requester_t last_eng;         // Last bus winner.
	string               test_name;
	int                  seed = 32'h6c30b503;
	int                  errors;
	int                  checks;
	int                  tests_run;
	int                  test_err0;
	int                  test_chk0;

	gf_coprocessor i_gf_coprocessor (
		.clk(clk), .arst_n(arst_n),
		.host_we(host_we), .host_waddr(host_waddr), .host_wdata(host_wdata),
		.host_raddr(host_raddr), .host_rdata(host_rdata),
		.mul_start(mul_start), .mul_op(mul_op), .mul_dst(mul_dst),
		.mul_src_a(mul_src_a), .mul_src_b(mul_src_b), .mul_busy(mul_busy),
		.div_start(div_start), .div_dst(div_dst), .div_numer(div_numer),
		.div_denom(div_denom), .div_busy(div_busy), .div_zero(div_zero)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk; // 4 ns period.

	a_value: assert property (@(posedge clk) disable iff (!arst_n)
		chk_en |-> host_rdata == chk_exp)
		else begin
			$display("Mismatch %s: expected %h, actual %h", test_name, chk_exp,
				$sampled(host_rdata));
			errors++;
		end

	a_zero_seen: assert property (@(posedge clk) disable iff (!arst_n)
		chk_en && chk_zero |-> zero_seen)
		else begin
			$display("%s: div_zero never went high for a zero denominator", test_name);
			errors++;
		end

	a_zero_low: assert property (@(posedge clk) disable iff (!arst_n)
		nz_mode |-> !div_zero)
		else begin
			$display("%s: div_zero went high with a nonzero denominator", test_name);
			errors++;
		end

	// Round-robin order of the first write when both engines run.
	a_first_mul: assert property (@(posedge clk) disable iff (!arst_n)
		dual_watch && $fell(mul_busy) && div_busy |-> first_exp == cop_pkg::REQ_MUL)
		else begin
			$display("%s: multiplier finished first out of round-robin order", test_name);
			errors++;
		end

	a_first_div: assert property (@(posedge clk) disable iff (!arst_n)
		dual_watch && $fell(div_busy) && mul_busy |-> first_exp == cop_pkg::REQ_DIV)
		else begin
			$display("%s: divider finished first out of round-robin order", test_name);
			errors++;
		end

	// LSB first, shifting B by alpha each step.
	function automatic gf_pkg::elem_t field_mul(input gf_pkg::elem_t a, input gf_pkg::elem_t b);
		gf_pkg::elem_t p;
		gf_pkg::elem_t s;
		logic          carry;
		p = '0;
		s = b;
		for (int i = 0; i < `GF_M; i++) begin
			if (a[i]) p = p ^ s;
			carry = s[`GF_M-1];
			s = s << 1;
			if (carry) s = s ^ `GF_POLY; // x^M folds back to the low terms.
		end
		return p;
	endfunction

	// Quotient through an exhaustive inverse search, zero for d = 0.
	function automatic gf_pkg::elem_t field_quot(input gf_pkg::elem_t n, input gf_pkg::elem_t d);
		gf_pkg::elem_t inv;
		inv = '0;
		for (int x = 1; x < (1 << `GF_M); x++) begin
			if (field_mul(d, gf_pkg::elem_t'(x)) == gf_pkg::elem_t'(1)) inv = gf_pkg::elem_t'(x);
		end
		return field_mul(n, inv);
	endfunction

	function automatic gf_pkg::elem_t rand_elem();
		return gf_pkg::elem_t'($random(seed));
	endfunction

	function automatic logic [`GF_AW-1:0] rand_reg();
		return `GF_AW'($random(seed));
	endfunction

	// Register from the lower or upper half of the file.
	function automatic logic [`GF_AW-1:0] half_reg(input logic upper);
		logic [`GF_AW-1:0] r;
		r = rand_reg();
		return {upper, r[`GF_AW-2:0]};
	endfunction

	task automatic host_write(input logic [`GF_AW-1:0] a, input gf_pkg::elem_t v);
		host_we    = 1'b1;
		host_waddr = a;
		host_wdata = v;
		@(negedge clk);
		host_we  = 1'b0;
		model[a] = v;
	endtask

	task automatic load_regs(input logic nonzero);
		gf_pkg::elem_t v;
		for (int i = 0; i < `GF_REGS; i++) begin
			v = rand_elem();
			if (nonzero && v == '0) v = gf_pkg::elem_t'(1);
			host_write(`GF_AW'(i), v);
		end
	endtask

	task automatic check_reg(input logic [`GF_AW-1:0] a);
		host_raddr = a;
		chk_exp    = model[a];
		chk_en     = 1'b1; // Compared at the next rising edge.
		checks++;
		@(negedge clk);
		chk_en = 1'b0;
	endtask

	// Waits until both engines are idle, noting any div_zero pulse.
	task automatic wait_idle(input int limit);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			if (div_zero) zero_seen = 1'b1;
			n++;
		end while ((mul_busy || div_busy) && n < limit);
		if (mul_busy || div_busy) begin
			$display("%s: engine still busy after %0d cycles", test_name, limit);
			errors++;
		end
	endtask

	task automatic run_mul(input gf_pkg::mul_op_t op, input logic [`GF_AW-1:0] d,
		input logic [`GF_AW-1:0] a, input logic [`GF_AW-1:0] b);
		mul_op    = op;
		mul_dst   = d;
		mul_src_a = a;
		mul_src_b = b;
		mul_start = 1'b1;
		@(negedge clk);
		mul_start = 1'b0;
		wait_idle(BOUND);
		model[d] = field_mul(model[a], (op == gf_pkg::OP_SQR) ? model[a] : model[b]);
		last_eng = cop_pkg::REQ_MUL;
		check_reg(d);
	endtask

	task automatic run_div(input logic [`GF_AW-1:0] d, input logic [`GF_AW-1:0] n,
		input logic [`GF_AW-1:0] q);
		div_dst   = d;
		div_numer = n;
		div_denom = q;
		zero_seen = 1'b0;
		div_start = 1'b1;
		@(negedge clk);
		div_start = 1'b0;
		wait_idle(BOUND);
		model[d] = field_quot(model[n], model[q]);
		last_eng = cop_pkg::REQ_DIV;
		check_reg(d);
	endtask

	// Both engines started together on disjoint registers.
	task automatic run_both(input logic [`GF_AW-1:0] md, input logic [`GF_AW-1:0] ma,
		input logic [`GF_AW-1:0] mb, input logic [`GF_AW-1:0] dd,
		input logic [`GF_AW-1:0] dn, input logic [`GF_AW-1:0] dq);
		mul_op    = gf_pkg::OP_MUL;
		mul_dst   = md;
		mul_src_a = ma;
		mul_src_b = mb;
		div_dst   = dd;
		div_numer = dn;
		div_denom = dq;
		first_exp = (last_eng == cop_pkg::REQ_DIV) ? cop_pkg::REQ_MUL : cop_pkg::REQ_DIV;
		dual_watch = 1'b1;
		mul_start  = 1'b1;
		div_start  = 1'b1;
		@(negedge clk);
		mul_start = 1'b0;
		div_start = 1'b0;
		wait_idle(2*BOUND);
		dual_watch = 1'b0;
		model[md] = field_mul(model[ma], model[mb]);
		model[dd] = field_quot(model[dn], model[dq]);
		last_eng  = (first_exp == cop_pkg::REQ_MUL) ? cop_pkg::REQ_DIV : cop_pkg::REQ_MUL;
		check_reg(md);
		check_reg(dd);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_err0 = errors;
		test_chk0 = checks;
	endtask

	task automatic end_test();
		tests_run++;
		$display("%s: %0d checks, %0d errors", test_name, checks - test_chk0,
			errors - test_err0);
	endtask

	initial begin
		int i;
		arst_n     = 1'b0;
		host_we    = 1'b0;
		host_waddr = '0;
		host_wdata = '0;
		host_raddr = '0;
		mul_start  = 1'b0;
		mul_op     = gf_pkg::OP_MUL;
		mul_dst    = '0;
		mul_src_a  = '0;
		mul_src_b  = '0;
		div_start  = 1'b0;
		div_dst    = '0;
		div_numer  = '0;
		div_denom  = '0;
		chk_en     = 1'b0;
		chk_exp    = '0;
		chk_zero   = 1'b0;
		zero_seen  = 1'b0;
		nz_mode    = 1'b0;
		dual_watch = 1'b0;
		first_exp  = cop_pkg::REQ_MUL;
		last_eng   = cop_pkg::REQ_DIV; // Arbiter state after reset.
		errors     = 0;
		checks     = 0;
		tests_run  = 0;
		test_name  = "reset";
		repeat (3) @(negedge clk); // Reset held for three cycles.
		arst_n = 1'b1;

		begin_test("host_rw");
		for (i = 0; i < `GF_REGS; i++) begin
			model[i] = '0; // Reset contents.
			check_reg(`GF_AW'(i));
		end
		for (i = 0; i < `GF_REGS; i++) host_write(`GF_AW'(i), rand_elem());
		for (i = 0; i < `GF_REGS; i++) check_reg(`GF_AW'(i));
		end_test();

		begin_test("mul");
		load_regs(1'b0);
		for (i = 0; i < OPS; i++) run_mul(gf_pkg::OP_MUL, rand_reg(), rand_reg(), rand_reg());
		end_test();

		begin_test("sqr");
		load_regs(1'b0);
		for (i = 0; i < OPS; i++) run_mul(gf_pkg::OP_SQR, rand_reg(), rand_reg(), rand_reg());
		end_test();

		begin_test("div");
		load_regs(1'b1); // Quotients of nonzero values stay nonzero.
		nz_mode = 1'b1;
		for (i = 0; i < OPS; i++) run_div(rand_reg(), rand_reg(), rand_reg());
		nz_mode = 1'b0;
		end_test();

		begin_test("div_zero");
		load_regs(1'b0);
		chk_zero = 1'b1;
		for (i = 0; i < OPS; i++) begin
			div_denom = rand_reg();
			host_write(div_denom, '0); // Force a zero denominator.
			run_div(rand_reg(), rand_reg(), div_denom);
		end
		chk_zero = 1'b0;
		end_test();

		begin_test("dual");
		load_regs(1'b1);
		nz_mode = 1'b1;
		for (i = 0; i < OPS; i++) begin
			// Odd rounds leave the multiplier as last winner.
			if ((i % 2) == 1) begin
				run_mul(gf_pkg::OP_SQR, half_reg(1'b0), half_reg(1'b0), half_reg(1'b0));
			end
			run_both(half_reg(1'b0), half_reg(1'b0), half_reg(1'b0),
				half_reg(1'b1), half_reg(1'b1), half_reg(1'b1));
		end
		nz_mode = 1'b0;
		end_test();

		$display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Ends a hung run, bound from test count and per-operation length.
	initial begin
		#(6 * OPS * BOUND * 4);
		$display("Watchdog expired before the tests finished");
		$display("Test failed");
		$finish;
	end

endmodule

//--- verilog/cop_pkg.sv
package cop_pkg;

	// Multiplier engine states.
	typedef enum logic [2:0] {
		MS_IDLE = 3'd0, // Waiting for start.
		MS_RD_A = 3'd1, // Fetch operand A.
		MS_RD_B = 3'd2, // Fetch operand B.
		MS_RUN  = 3'd3, // Serial multiply.
		MS_WR   = 3'd4  // Write back result.
	} mul_state_t;

	// Divider engine states.
	typedef enum logic [2:0] {
		DS_IDLE = 3'd0, // Waiting for start.
		DS_RD_D = 3'd1, // Fetch denominator.
		DS_RD_N = 3'd2, // Fetch numerator.
		DS_INV  = 3'd3, // Fermat inversion steps.
		DS_WR   = 3'd4  // Write back quotient.
	} div_state_t;

	// Engine bus requesters.
	typedef enum logic {
		REQ_MUL = 1'b0,
		REQ_DIV = 1'b1
	} requester_t;

endpackage

//--- verilog/gf_bus_arbiter.sv
`timescale 1ns/1ps
`include "gf_params.svh"

module gf_bus_arbiter (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              mul_req,   // Multiplier side.
	input  logic              mul_we,
	input  logic [`GF_AW-1:0] mul_addr,
	input  gf_pkg::elem_t     mul_wdata,
	output logic              mul_gnt,
	input  logic              div_req,   // Divider side.
	input  logic              div_we,
	input  logic [`GF_AW-1:0] div_addr,
	input  gf_pkg::elem_t     div_wdata,
	output logic              div_gnt,
	output logic              mem_we,    // To register file.
	output logic [`GF_AW-1:0] mem_addr,
	output gf_pkg::elem_t     mem_wdata
);

	cop_pkg::requester_t last; // Winner of the last granted cycle.

	// Lone requester wins, a tie goes to the one that lost last.
	assign mul_gnt = mul_req && (!div_req || last == cop_pkg::REQ_DIV);
	assign div_gnt = div_req && (!mul_req || last == cop_pkg::REQ_MUL);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			last <= cop_pkg::REQ_DIV; // Multiplier wins first tie.
		end else if (mul_gnt) begin
			last <= cop_pkg::REQ_MUL;
		end else if (div_gnt) begin
			last <= cop_pkg::REQ_DIV;
		end
	end

	// Steer winner onto the port.
	assign mem_we    = (mul_gnt && mul_we) || (div_gnt && div_we);
	assign mem_addr  = div_gnt ? div_addr : mul_addr;
	assign mem_wdata = div_gnt ? div_wdata : mul_wdata;

	a_one_hot_gnt: assert property (@(posedge clk) disable iff (!arst_n)
		!(mul_gnt && div_gnt))
		else $error("Both engines granted in one cycle");

	a_gnt_to_req: assert property (@(posedge clk) disable iff (!arst_n)
		(!mul_gnt || mul_req) && (!div_gnt || div_req))
		else $error("Grant given to an engine that did not request");

endmodule

//--- verilog/gf_coprocessor.sv
`timescale 1ns/1ps
`include "gf_params.svh"

module gf_coprocessor (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              host_we,    // Host register access.
	input  logic [`GF_AW-1:0] host_waddr,
	input  gf_pkg::elem_t     host_wdata,
	input  logic [`GF_AW-1:0] host_raddr,
	output gf_pkg::elem_t     host_rdata,
	input  logic              mul_start,  // Multiplier command.
	input  gf_pkg::mul_op_t   mul_op,
	input  logic [`GF_AW-1:0] mul_dst,
	input  logic [`GF_AW-1:0] mul_src_a,
	input  logic [`GF_AW-1:0] mul_src_b,
	output logic              mul_busy,
	input  logic              div_start,  // Divider command.
	input  logic [`GF_AW-1:0] div_dst,
	input  logic [`GF_AW-1:0] div_numer,
	input  logic [`GF_AW-1:0] div_denom,
	output logic              div_busy,
	output logic              div_zero
);

	logic              mul_req;
	logic              mul_gnt;
	logic              mul_we;
	logic [`GF_AW-1:0] mul_addr;
	gf_pkg::elem_t     mul_wdata;
	logic              div_req;
	logic              div_gnt;
	logic              div_we;
	logic [`GF_AW-1:0] div_addr;
	gf_pkg::elem_t     div_wdata;
	logic              mem_we;    // Arbitrated engine port.
	logic [`GF_AW-1:0] mem_addr;
	gf_pkg::elem_t     mem_wdata;
	gf_pkg::elem_t     mem_rdata; // Shared by both engines.

	gf_regfile i_gf_regfile (
		.clk(clk), .arst_n(arst_n),
		.we(mem_we), .addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata),
		.host_we(host_we), .host_waddr(host_waddr), .host_wdata(host_wdata),
		.host_raddr(host_raddr), .host_rdata(host_rdata)
	);

	gf_bus_arbiter i_gf_bus_arbiter (
		.clk(clk), .arst_n(arst_n),
		.mul_req(mul_req), .mul_we(mul_we), .mul_addr(mul_addr),
		.mul_wdata(mul_wdata), .mul_gnt(mul_gnt),
		.div_req(div_req), .div_we(div_we), .div_addr(div_addr),
		.div_wdata(div_wdata), .div_gnt(div_gnt),
		.mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

	gf_mul_engine i_gf_mul_engine (
		.clk(clk), .arst_n(arst_n),
		.start(mul_start), .op(mul_op), .dst(mul_dst),
		.src_a(mul_src_a), .src_b(mul_src_b),
		.gnt(mul_gnt), .rdata(mem_rdata), .busy(mul_busy),
		.req(mul_req), .we(mul_we), .addr(mul_addr), .wdata(mul_wdata)
	);

	gf_div_engine i_gf_div_engine (
		.clk(clk), .arst_n(arst_n),
		.start(div_start), .dst(div_dst), .numer(div_numer), .denom(div_denom),
		.gnt(div_gnt), .rdata(mem_rdata), .busy(div_busy), .zero(div_zero),
		.req(div_req), .we(div_we), .addr(div_addr), .wdata(div_wdata)
	);

endmodule

//--- verilog/gf_div_engine.sv
`timescale 1ns/1ps
`include "gf_params.svh"

module gf_div_engine (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              start,  // Command strobe, ignored while busy.
	input  logic [`GF_AW-1:0] dst,
	input  logic [`GF_AW-1:0] numer,
	input  logic [`GF_AW-1:0] denom,
	input  logic              gnt,    // Bus grant.
	input  gf_pkg::elem_t     rdata,  // Shared read data.
	output logic              busy,
	output logic              zero,   // Division by zero, with the write.
	output logic              req,
	output logic              we,
	output logic [`GF_AW-1:0] addr,
	output gf_pkg::elem_t     wdata
);

	localparam int CW = $clog2(`GF_M);
	localparam logic [CW-1:0] LAST = CW'(`GF_M - 2); // GF_M-1 inversion steps.

	cop_pkg::div_state_t state;
	logic [CW-1:0]       cnt;
	logic [`GF_AW-1:0]   dst_q;
	logic [`GF_AW-1:0]   numer_q;
	logic [`GF_AW-1:0]   denom_q;
	gf_pkg::elem_t       pw;     // Running power d^(2^k).
	gf_pkg::elem_t       prod;   // Running product of powers.
	gf_pkg::elem_t       n_q;    // Numerator value.
	logic                zero_q; // Denominator was zero.
	gf_pkg::elem_t       sq_y;
	gf_pkg::elem_t       mul_y;

	// Parallel standard-basis multiply, MSB first shift and reduce.
	function automatic gf_pkg::elem_t gf_mul(input gf_pkg::elem_t a, input gf_pkg::elem_t b);
		gf_pkg::elem_t p;
		p = '0;
		for (int i = `GF_M - 1; i >= 0; i--) begin
			p = {p[`GF_M-2:0], 1'b0} ^ (`GF_POLY & {`GF_M{p[`GF_M-1]}});
			if (a[i]) p = p ^ b;
		end
		return p;
	endfunction

	// Squarer. Spread bits to even positions, then fold the top down.
	function automatic gf_pkg::elem_t gf_sqr(input gf_pkg::elem_t a);
		logic [2*`GF_M-2:0] t;
		t = '0;
		for (int i = 0; i < `GF_M; i++) begin
			t[2*i] = a[i];
		end
		for (int i = 2*`GF_M - 2; i >= `GF_M; i--) begin
			if (t[i]) t[i-`GF_M +: `GF_M] = t[i-`GF_M +: `GF_M] ^ `GF_POLY; // x^M = POLY.
		end
		return t[`GF_M-1:0];
	endfunction

	assign sq_y  = gf_sqr((state == cop_pkg::DS_RD_D) ? rdata : pw);
	assign mul_y = gf_mul(prod, (state == cop_pkg::DS_WR) ? n_q : pw); // Shared multiplier.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= cop_pkg::DS_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				cop_pkg::DS_IDLE: if (start) begin
					state <= cop_pkg::DS_RD_D;
					cnt   <= '0;
				end
				cop_pkg::DS_RD_D: if (gnt) state <= cop_pkg::DS_RD_N;
				cop_pkg::DS_RD_N: if (gnt) state <= cop_pkg::DS_INV;
				cop_pkg::DS_INV: begin
					cnt <= cnt + 1'b1;
					if (cnt == LAST) state <= cop_pkg::DS_WR;
				end
				cop_pkg::DS_WR: if (gnt) state <= cop_pkg::DS_IDLE;
				default: state <= cop_pkg::DS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == cop_pkg::DS_IDLE && start) begin
			dst_q   <= dst;
			numer_q <= numer;
			denom_q <= denom;
		end
		if (state == cop_pkg::DS_RD_D && gnt) begin
			pw     <= sq_y;                 // d^2.
			prod   <= gf_pkg::elem_t'(1);   // Field one.
			zero_q <= (rdata == '0);
		end
		if (state == cop_pkg::DS_RD_N && gnt) n_q <= rdata;
		if (state == cop_pkg::DS_INV) begin
			prod <= mul_y;
			pw   <= sq_y;
		end
	end

	assign busy  = (state != cop_pkg::DS_IDLE);
	assign req   = (state == cop_pkg::DS_RD_D) || (state == cop_pkg::DS_RD_N)
		|| (state == cop_pkg::DS_WR);
	assign we    = (state == cop_pkg::DS_WR);
	assign wdata = zero_q ? '0 : mul_y;     // n * d^-1, forced zero for d = 0.
	assign zero  = we && gnt && zero_q;     // One cycle, on the granted write.

	always_comb begin
		case (state)
			cop_pkg::DS_RD_D: addr = denom_q;
			cop_pkg::DS_RD_N: addr = numer_q;
			default:          addr = dst_q;
		endcase
	end

	// Busy only ends on a write the arbiter accepted.
	a_busy_end: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(busy) |-> $past(we && gnt))
		else $error("Divider left busy without a granted write");

endmodule

//--- verilog/gf_mul_engine.sv
`timescale 1ns/1ps
`include "gf_params.svh"

module gf_mul_engine (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              start,  // Command strobe, ignored while busy.
	input  gf_pkg::mul_op_t   op,
	input  logic [`GF_AW-1:0] dst,
	input  logic [`GF_AW-1:0] src_a,
	input  logic [`GF_AW-1:0] src_b,
	input  logic              gnt,    // Bus grant.
	input  gf_pkg::elem_t     rdata,  // Shared read data.
	output logic              busy,
	output logic              req,
	output logic              we,
	output logic [`GF_AW-1:0] addr,
	output gf_pkg::elem_t     wdata
);

	localparam int CW = $clog2(`GF_M + 1);
	localparam logic [CW-1:0] LAST = CW'(`GF_M - 1); // Final compute cycle.

	cop_pkg::mul_state_t state;
	logic [CW-1:0]       cnt;      // Compute cycle counter.
	gf_pkg::mul_op_t     op_q;     // Latched command.
	logic [`GF_AW-1:0]   dst_q;
	logic [`GF_AW-1:0]   src_a_q;
	logic [`GF_AW-1:0]   src_b_q;
	gf_pkg::elem_t       a_q;      // Serial operand, MSB consumed first.
	gf_pkg::elem_t       b_q;      // Parallel operand.
	gf_pkg::elem_t       acc;
	gf_pkg::elem_t       acc_next;

	// acc*alpha reduced, plus B when the current A bit is set.
	assign acc_next = {acc[`GF_M-2:0], 1'b0}
		^ (`GF_POLY & {`GF_M{acc[`GF_M-1]}})
		^ (b_q & {`GF_M{a_q[`GF_M-1]}});

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= cop_pkg::MS_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				cop_pkg::MS_IDLE: if (start) begin
					state <= cop_pkg::MS_RD_A;
					cnt   <= '0;
				end
				cop_pkg::MS_RD_A: if (gnt) begin
					// Squaring skips the second fetch.
					state <= (op_q == gf_pkg::OP_SQR) ? cop_pkg::MS_RUN : cop_pkg::MS_RD_B;
				end
				cop_pkg::MS_RD_B: if (gnt) state <= cop_pkg::MS_RUN;
				cop_pkg::MS_RUN: begin
					cnt <= cnt + 1'b1;
					if (cnt == LAST) state <= cop_pkg::MS_WR;
				end
				cop_pkg::MS_WR: if (gnt) state <= cop_pkg::MS_IDLE; // Busy drops here.
				default: state <= cop_pkg::MS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == cop_pkg::MS_IDLE && start) begin
			op_q    <= op;
			dst_q   <= dst;
			src_a_q <= src_a;
			src_b_q <= src_b;
		end
		if (state == cop_pkg::MS_RD_A && gnt) begin
			a_q <= rdata;
			b_q <= rdata; // B equals A for a square.
			acc <= '0;
		end
		if (state == cop_pkg::MS_RD_B && gnt) b_q <= rdata;
		if (state == cop_pkg::MS_RUN) begin
			acc <= acc_next;
			a_q <= {a_q[`GF_M-2:0], 1'b0}; // Next A bit to the top.
		end
	end

	assign busy  = (state != cop_pkg::MS_IDLE);
	assign req   = (state == cop_pkg::MS_RD_A) || (state == cop_pkg::MS_RD_B)
		|| (state == cop_pkg::MS_WR);
	assign we    = (state == cop_pkg::MS_WR);
	assign wdata = acc;

	always_comb begin
		case (state)
			cop_pkg::MS_RD_A: addr = src_a_q;
			cop_pkg::MS_RD_B: addr = src_b_q;
			default:          addr = dst_q; // Write target.
		endcase
	end

	a_cnt_bound: assert property (@(posedge clk) disable iff (!arst_n)
		cnt <= CW'(`GF_M))
		else $error("Multiplier compute counter passed GF_M");

	// Compute phase lasts exactly GF_M cycles, then writes.
	a_run_len: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(state == cop_pkg::MS_RUN) |->
			(state == cop_pkg::MS_RUN)[*`GF_M] ##1 (state == cop_pkg::MS_WR))
		else $error("Multiplier compute phase has wrong length");

endmodule

//--- verilog/gf_params.svh
`ifndef GF_PARAMS_SVH
`define GF_PARAMS_SVH

// Field GF(2^m) with m = 4.
`define GF_M 4

// Low terms of x^4+x+1, the x^4 term is implied.
`define GF_POLY 4'b0011

// Register file depth.
`define GF_REGS 8

// Register address width, log2 of GF_REGS.
`define GF_AW 3

`endif

//--- verilog/gf_pkg.sv
`include "gf_params.svh"

package gf_pkg;

	// One field element, standard basis, bit i is the alpha^i term.
	typedef logic [`GF_M-1:0] elem_t;

	// Multiplier command.
	typedef enum logic {
		OP_MUL = 1'b0, // A times B.
		OP_SQR = 1'b1  // A squared, B ignored.
	} mul_op_t;

endpackage

//--- verilog/gf_regfile.sv
`timescale 1ns/1ps
`include "gf_params.svh"

module gf_regfile (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              we,         // Engine port, arbitrated.
	input  logic [`GF_AW-1:0] addr,
	input  gf_pkg::elem_t     wdata,
	output gf_pkg::elem_t     rdata,
	input  logic              host_we,    // Host write port.
	input  logic [`GF_AW-1:0] host_waddr,
	input  gf_pkg::elem_t     host_wdata,
	input  logic [`GF_AW-1:0] host_raddr, // Host read port.
	output gf_pkg::elem_t     host_rdata
);

	gf_pkg::elem_t mem [`GF_REGS]; // Element storage.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `GF_REGS; i++) begin
				mem[i] <= '0; // All registers start at zero.
			end
		end else if (we) begin
			mem[addr] <= wdata; // Engine result.
		end else if (host_we) begin
			mem[host_waddr] <= host_wdata;
		end
	end

	assign rdata      = mem[addr];       // Asynchronous read, same-cycle data.
	assign host_rdata = mem[host_raddr];

	// Host loads only while both engines are idle.
	a_no_dual_write: assert property (@(posedge clk) disable iff (!arst_n)
		!(we && host_we))
		else $error("Engine and host write in the same cycle");

endmodule
